// File: verification/femtoCoreStim.txt
# P address word0 .. word7 : eight memory words in hex starting at address
# E test address data : expected store in order, test number then hex address and data
P 000 12300093 FFB00113 002081B3 20302023 402081B3 20302223 001121B3 20302423
P 020 001131B3 20302623 0020C1B3 20302823 0020E1B3 20302A23 0020F1B3 20302C23
P 040 EDC08193 20302E23 8F00F0B7 05B08093 00400113 01F00213 002091B3 22302023
P 060 0020D1B3 22302223 4020D1B3 22302423 000091B3 22302623 4040D1B3 22302823
P 080 01F09193 22302A23 4080D193 22302C23 00009193 22302E23 FFE00093 00300113
P 0A0 05A00293 0BA00313 00108463 24602023 00208463 24502023 00209463 24602223
P 0C0 00109463 24502223 0020C463 24602423 00114463 24502423 00115463 24602623
P 0E0 0020D463 24502623 00116463 24602823 0020E463 24502823 0020F463 24602A23
P 100 00117463 24502A23 008003EF 24602C23 24702C23 00012417 24802E23 ABCDE4B7
P 120 26902023 13000513 004505E7 26602223 26602223 26B02223 3E902823 3F002683
P 140 26D02423 3FC02703 26E02623 05500013 00208033 26002823 0000006F 00000013
P 3E0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 600DF00D
E 1 200 0000011E
E 1 204 00000128
E 1 208 00000001
E 1 20C 00000000
E 1 210 FFFFFED8
E 1 214 FFFFFFFB
E 1 218 00000123
E 1 21C FFFFFFFF
E 2 220 F00F05B0
E 2 224 08F00F05
E 2 228 F8F00F05
E 2 22C 8F00F05B
E 2 230 FFFFFFFF
E 2 234 80000000
E 2 238 FF8F00F0
E 2 23C 8F00F05B
E 3 240 0000005A
E 3 244 0000005A
E 3 248 0000005A
E 3 24C 0000005A
E 3 250 0000005A
E 3 254 0000005A
E 4 258 0000010C
E 4 25C 00012114
E 4 260 ABCDE000
E 4 264 0000012C
E 5 3F0 ABCDE000
E 5 268 ABCDE000
E 5 26C 600DF00D
E 6 270 00000000

// File: femtoCore.f
rtl/riscvIsaPkg.sv
rtl/coreCfgPkg.sv
rtl/coreIf.sv
rtl/instrDecoder.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/controlFsm.sv
rtl/femtoCore.sv
verification/femtoCore_properties.sv
verification/storeChecker.sv
verification/femtoCoreTb.sv

// File: Bender.yml
package:
  name: femtoCore

sources:
  - rtl/riscvIsaPkg.sv
  - rtl/coreCfgPkg.sv
  - rtl/coreIf.sv
  - rtl/instrDecoder.sv
  - rtl/registerFile.sv
  - rtl/aluUnit.sv
  - rtl/controlFsm.sv
  - rtl/femtoCore.sv
  - target: simulation
    files:
      - verification/femtoCore_properties.sv
      - verification/storeChecker.sv
      - verification/femtoCoreTb.sv

// File: verification/femtoCoreTb.sv
// Testbench running a program image on the femtoCore with a memory model and watchdog
module femtoCoreTb import riscvIsaPkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MemWords      = 256;  // 1 KB memory model
   localparam int CycleNs       = 20;
   localparam int ResetCycles   = 8;
   localparam int CyclesPerWord = 40;   // Watchdog budget per program word
   localparam int WordsPerLine  = 8;

   logic                    clk;
   logic                    reset;
   logic [XLEN-1:0]         memAddr;
   logic [XLEN-1:0]         memWdata;
   logic [NumByteLanes-1:0] memWmask;
   logic [XLEN-1:0]         memRdata;
   logic                    memRstrb;
   logic                    allDone;
   int                      errorCount;
   logic [XLEN-1:0]         mem [MemWords];
   int                      progWords;
   logic                    timedOut;

   femtoCore u_dut (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRdata(memRdata), .memRstrb(memRstrb)
   );

   storeChecker u_check (
      .clk(clk), .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
      .allDone(allDone), .errorCount(errorCount)
   );

   always #(CycleNs / 2) clk = ~clk;

   // Memory model answering a read strobe before the next rising edge
   always @(negedge clk) begin
      if (memRstrb) memRdata <= mem[memAddr[9:2]];
      if (memWmask == '1) mem[memAddr[9:2]] <= memWdata;  // Full word store
   end

   // ********************************************************************
   // Program image and expected stores from the stim file
   task automatic loadStim();
      int              fd;
      int              code;
      int              test;
      int              i;
      logic [8*8-1:0]  tag;
      logic [8*160-1:0] rest;
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] data;
      logic [XLEN-1:0] w [WordsPerLine];
      fd = $fopen("verification/femtoCoreStim.txt", "r");
      if (fd == 0) $display("Could not open the stimulus file");
      while (fd != 0 && $fscanf(fd, "%s", tag) == 1) begin
         if (tag == "#") begin
            code = $fgets(rest, fd);      // Comment line
         end else if (tag == "P") begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", addr,
                           w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
            for (i = 0; i < WordsPerLine; i++) mem[addr[9:2] + 8'(i)] = w[i];
            progWords += WordsPerLine;
         end else if (tag == "E") begin
            code = $fscanf(fd, "%d %h %h", test, addr, data);
            u_check.addExpected(test, addr, data);
         end
      end
      if (fd != 0) $fclose(fd);
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b0;
      memRdata  = '0;
      progWords = 0;
      timedOut  = 1'b0;
      for (int a = 0; a < MemWords; a++) mem[a] = {16'hBAD0, 16'(a)};  // Word index in low half
      loadStim();
      repeat (ResetCycles) @(negedge clk);
      reset = 1'b1;
      // Run until the last expected store or the watchdog fires
      fork
         wait (allDone);
         begin
            repeat (progWords * CyclesPerWord) @(posedge clk);
            timedOut = 1'b1;
         end
      join_any
      repeat (2) @(negedge clk);
      if (timedOut) begin
         $display("Timeout after %0d cycles without all expected stores",
                  progWords * CyclesPerWord);
         u_check.reportMissing();
      end
      u_check.printSummary();
      if (!timedOut && progWords != 0 && errorCount == 0 &&
          u_dut.u_props.assertFails == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: verification/storeChecker.sv
// Store checker comparing each DUT store with the expected store list
module storeChecker import riscvIsaPkg::*; (
   input  logic                    clk,
   input  logic [XLEN-1:0]         memAddr,
   input  logic [XLEN-1:0]         memWdata,
   input  logic [NumByteLanes-1:0] memWmask,
   output logic                    allDone,     // Last expected store seen
   output int                      errorCount
);

   timeunit 1ns;
   timeprecision 100ps;

   int              expTest[$];   // Test number of each expected store
   logic [XLEN-1:0] expAddr[$];
   logic [XLEN-1:0] expData[$];
   int              testsPassed;
   int              testsFailed;
   int              testErrors;   // Errors in the running test

   initial begin
      allDone     = 1'b0;
      errorCount  = 0;
      testsPassed = 0;
      testsFailed = 0;
      testErrors  = 0;
   end

   task automatic addExpected(input int test, input logic [XLEN-1:0] addr, data);
      expTest.push_back(test);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   // One line per finished test
   task automatic finishTest(input int test);
      if (testErrors == 0) begin
         $display("Test %0d pass", test);
         testsPassed++;
      end else begin
         $display("Test %0d fail, %0d errors", test, testErrors);
         testsFailed++;
      end
      testErrors = 0;
      if (expTest.size() == 0) allDone = 1'b1;
   endtask

   task automatic checkStore();
      int              test;
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] data;
      test = expTest.pop_front();
      addr = expAddr.pop_front();
      data = expData.pop_front();
      if (memAddr !== addr) begin
         $display("Fail memAddr expected %h got %h", addr, memAddr);
         errorCount++;
         testErrors++;
      end
      if (memWdata !== data) begin
         $display("Fail memWdata expected %h got %h", data, memWdata);
         errorCount++;
         testErrors++;
      end
      if (expTest.size() == 0 || expTest[0] != test) finishTest(test);  // Last store of test
   endtask

   // ********************************************************************
   // Sample stores away from the rising edge
   always @(negedge clk) begin
      if (memWmask != '0) begin
         if (expTest.size() == 0) begin
            $display("Extra store of %h to address %h after the last expected one",
                     memWdata, memAddr);
            errorCount++;
         end else begin
            checkStore();
         end
      end
   end

   task automatic reportMissing();
      if (expTest.size() != 0) begin
         $display("%0d expected stores never happened, first one in test %0d at address %h",
                  expTest.size(), expTest[0], expAddr[0]);
         errorCount += expTest.size();
         testsFailed++;                    // Test that was running
      end
   endtask

   task automatic printSummary();
      $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
   endtask

endmodule

// File: verification/femtoCore_properties.sv
// Bus protocol assertions for the femtoCore memory interface
module femtoCoreProperties import riscvIsaPkg::*; (
   input logic                    clk,
   input logic                    reset,
   input logic [XLEN-1:0]         memAddr,
   input logic [NumByteLanes-1:0] memWmask,
   input logic                    memRstrb
);

   timeunit 1ns;
   timeprecision 100ps;

   int assertFails;  // Failed assertions so far

   initial assertFails = 0;

   // Read and write never share a cycle
   assert property (@(posedge clk) disable iff (!reset) !(memRstrb && memWmask != '0))
      else begin
         $error("Read strobe and write mask active together");
         assertFails++;
      end

   // Full word writes only
   assert property (@(posedge clk) disable iff (!reset) memWmask == '0 || memWmask == '1)
      else begin
         $error("Partial write mask %h", memWmask);
         assertFails++;
      end

   assert property (@(posedge clk) disable iff (!reset) memRstrb |=> !memRstrb)
      else begin
         $error("Read strobe high for two cycles");
         assertFails++;
      end

   // Word aligned bus accesses
   assert property (@(posedge clk) disable iff (!reset)
                    (memRstrb || memWmask != '0) |-> memAddr[1:0] == 2'b00)
      else begin
         $error("Unaligned bus address %h", memAddr);
         assertFails++;
      end

endmodule

bind femtoCore femtoCoreProperties u_props (
   .clk(clk), .reset(reset), .memAddr(memAddr), .memWmask(memWmask), .memRstrb(memRstrb)
);

// File: rtl/femtoCore.sv
// RV32I multi-cycle core top level on a simple strobe memory bus
module femtoCore import riscvIsaPkg::*; (
   input  logic                    clk,
   input  logic                    reset,     // Synchronous, active low
   output logic [XLEN-1:0]         memAddr,
   output logic [XLEN-1:0]         memWdata,
   output logic [NumByteLanes-1:0] memWmask,  // 1111 for one cycle per store
   input  logic [XLEN-1:0]         memRdata,  // Valid the cycle after memRstrb
   output logic                    memRstrb
);

   decodeIf  decBus ();
   operandIf opBus ();

   logic            latchInstr;
   logic            writeEn;
   logic [XLEN-1:0] writeData;

   instrDecoder u_decoder (
      .clk(clk), .latchInstr(latchInstr), .memRdata(memRdata), .dec(decBus.decoder)
   );

   registerFile u_regFile (
      .clk(clk), .regs(decBus.regs), .ops(opBus.regs),
      .writeEn(writeEn), .writeData(writeData)
   );

   aluUnit u_alu (.clk(clk), .dec(decBus.alu), .ops(opBus.alu));

   controlFsm u_ctrl (
      .clk(clk), .reset(reset), .dec(decBus.ctrl), .ops(opBus.ctrl),
      .memRdata(memRdata), .latchInstr(latchInstr), .writeEn(writeEn),
      .writeData(writeData), .memAddr(memAddr), .memRstrb(memRstrb),
      .memWmask(memWmask), .memWdata(memWdata)
   );

endmodule

// File: rtl/controlFsm.sv
// Control FSM with program counter, address adder, write-back select and bus strobes
module controlFsm import riscvIsaPkg::*, coreCfgPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   decodeIf.ctrl                   dec,
   operandIf.ctrl                  ops,
   input  logic [XLEN-1:0]         memRdata,
   output logic                    latchInstr,
   output logic                    writeEn,
   output logic [XLEN-1:0]         writeData,
   output logic [XLEN-1:0]         memAddr,
   output logic                    memRstrb,
   output logic [NumByteLanes-1:0] memWmask,
   output logic [XLEN-1:0]         memWdata
);

   stateT                state;
   logic                 coreRunning;  // Low in the first cycle after reset
   logic [AddrWidth-1:0] pc;
   logic [AddrWidth-1:0] pcPlus4;
   logic [AddrWidth-1:0] addrReg;      // Drives memAddr
   logic [AddrWidth-1:0] addrAdderIn1;
   logic [AddrWidth-1:0] addrAdder;    // Registered rs1/PC + imm
   logic                 isLoad;
   logic                 isStore;
   logic                 isBranch;
   logic                 isJal;
   logic                 isJalr;
   logic                 isAlu;
   logic                 aluWait;
   logic                 jumpTaken;

   assign isLoad    = (dec.opcode == OpLoad);
   assign isStore   = (dec.opcode == OpStore);
   assign isBranch  = (dec.opcode == OpBranch);
   assign isJal     = (dec.opcode == OpJal);
   assign isJalr    = (dec.opcode == OpJalr);
   assign isAlu     = (dec.opcode == OpAluReg) || (dec.opcode == OpAluImm);
   assign aluWait   = isAlu & ops.aluBusy;   // Shift still running
   assign jumpTaken = isJal | isJalr | (isBranch & ops.branchTaken);

   // ********************************************************************
   // Address adder, rs1 based for loads, stores and JALR
   assign pcPlus4      = pc + AddrWidth'(4);
   assign addrAdderIn1 = (isLoad | isStore | isJalr) ? ops.rs1Data[AddrWidth-1:0] : pc;

   always_ff @(posedge clk) begin
      addrAdder <= addrAdderIn1 + dec.addrImm[AddrWidth-1:0];  // Valid in StExecute
   end

   // ********************************************************************
   // Write-back value and enable
   always_comb begin
      case (dec.opcode)
         OpLui:         writeData = dec.upperImm;
         OpAuipc:       writeData = XLEN'(addrAdder);
         OpJal, OpJalr: writeData = XLEN'(pcPlus4);  // Link address
         OpLoad:        writeData = memRdata;
         default:       writeData = ops.aluResult;
      endcase
   end

   assign writeEn = (dec.rd != '0) & ~isBranch & ~isStore &
                    (((state == StExecute) & ~isLoad & ~aluWait) |
                     ((state == StWaitAluMem) & ~aluWait));

   // Bus and block strobes, all from the state
   assign latchInstr   = (state == StWaitInstr);
   assign ops.aluStart = (state == StAddrAlu) & isAlu;
   assign memRstrb     = (coreRunning & (state == StFetchInstr)) | (state == StLoad);
   assign memWmask     = {NumByteLanes{state == StStore}};  // Full word only
   assign memWdata     = ops.rs2Data;
   assign memAddr      = {{(XLEN-AddrWidth){1'b0}}, addrReg};

   // ********************************************************************
   // State register
   always_ff @(posedge clk) begin
      if (!reset) begin
         state       <= StFetchInstr;
         pc          <= ResetAddr;
         addrReg     <= ResetAddr;
         coreRunning <= 1'b0;
      end else begin
         coreRunning <= 1'b1;
         unique case (state)
            StFetchInstr: if (coreRunning) state <= StWaitInstr;  // Hold until strobe out
            StWaitInstr:  state <= StFetchRegs;
            StFetchRegs:  state <= StAddrAlu;
            StAddrAlu:    state <= StExecute;
            StExecute: begin
               pc      <= jumpTaken ? addrAdder : pcPlus4;
               addrReg <= (isLoad | isStore | jumpTaken) ? addrAdder : pcPlus4;
               if (isLoad)       state <= StLoad;
               else if (isStore) state <= StStore;
               else if (aluWait) state <= StWaitAluMem;
               else              state <= StFetchInstr;
            end
            StLoad:       state <= StWaitAluMem;  // Data arrives next cycle
            StWaitAluMem: begin
               if (!aluWait) begin
                  addrReg <= pc;                    // Back to the fetch address
                  state   <= StFetchInstr;
               end
            end
            StStore: begin
               addrReg <= pc;
               state   <= StFetchInstr;
            end
            default:      state <= StFetchInstr;
         endcase
      end
   end

endmodule

// File: rtl/aluUnit.sv
// ALU with adder, compare, logic ops, serial shifter and latched branch predicate
module aluUnit import riscvIsaPkg::*; (
   input  logic  clk,
   decodeIf.alu  dec,
   operandIf.alu ops
);

   logic [XLEN-1:0]       aluIn1;
   logic [XLEN-1:0]       aluIn2;
   logic [XLEN-1:0]       aluPlus;
   logic [XLEN:0]         aluMinus;  // Extra bit is the borrow
   logic                  isLt;
   logic                  isLtu;
   logic                  isEq;
   logic                  isShift;
   logic [XLEN-1:0]       aluReg;    // Result and shift register
   logic [ShamtWidth-1:0] shamt;     // Remaining shift steps
   aluFuncT               aluFunc;
   branchFuncT            brFunc;

   assign aluFunc = aluFuncT'(dec.funct3);
   assign brFunc  = branchFuncT'(dec.funct3);
   assign isShift = (aluFunc == FnSll) || (aluFunc == FnSr);

   assign aluIn1 = ops.rs1Data;
   assign aluIn2 = (dec.opcode == OpAluReg || dec.opcode == OpBranch) ? ops.rs2Data
                                                                      : dec.aluImm;

   // ********************************************************************
   // One subtraction gives SUB and all three compares
   assign aluPlus  = aluIn1 + aluIn2;
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + (XLEN+1)'(1);
   assign isLtu    = aluMinus[XLEN];
   assign isLt     = (aluIn1[XLEN-1] ^ aluIn2[XLEN-1]) ? aluIn1[XLEN-1] : aluMinus[XLEN];
   assign isEq     = (aluMinus[XLEN-1:0] == '0);

   always_ff @(posedge clk) begin
      if (ops.aluStart) begin
         unique case (aluFunc)
            FnAddSub:    aluReg <= (dec.altOp && dec.isRegOp) ? aluMinus[XLEN-1:0] : aluPlus;
            FnSlt:       aluReg <= XLEN'(isLt);
            FnSltu:      aluReg <= XLEN'(isLtu);
            FnXor:       aluReg <= aluIn1 ^ aluIn2;
            FnOr:        aluReg <= aluIn1 | aluIn2;
            FnAnd:       aluReg <= aluIn1 & aluIn2;
            FnSll, FnSr: aluReg <= aluIn1;                     // Shift source
         endcase
         shamt <= isShift ? aluIn2[ShamtWidth-1:0] : '0;    // Zero keeps busy low
      end else if (shamt != '0) begin
         // One bit per cycle, SRA fills with the sign
         shamt  <= shamt - ShamtWidth'(1);
         aluReg <= (aluFunc == FnSr) ? {dec.altOp & aluReg[XLEN-1], aluReg[XLEN-1:1]}
                                     : {aluReg[XLEN-2:0], 1'b0};
      end
   end

   // ********************************************************************
   // Branch predicate, registered every cycle
   always_ff @(posedge clk) begin
      case (brFunc)
         BrEq:    ops.branchTaken <= isEq;
         BrNe:    ops.branchTaken <= !isEq;
         BrLt:    ops.branchTaken <= isLt;
         BrGe:    ops.branchTaken <= !isLt;
         BrLtu:   ops.branchTaken <= isLtu;
         BrGeu:   ops.branchTaken <= !isLtu;
         default: ops.branchTaken <= 1'b0;  // Unused funct3
      endcase
   end

   assign ops.aluResult = aluReg;
   assign ops.aluBusy   = (shamt != '0);

endmodule

// File: rtl/registerFile.sv
// Register file with 32 entries, registered dual read and a single write port
module registerFile import riscvIsaPkg::*; (
   input  logic            clk,
   decodeIf.regs           regs,
   operandIf.regs          ops,
   input  logic            writeEn,
   input  logic [XLEN-1:0] writeData
);

   logic [XLEN-1:0] regArray [NumRegs];

   always_ff @(posedge clk) begin
      // Read data follows the addresses by one cycle
      ops.rs1Data <= (regs.rs1Addr == '0) ? '0 : regArray[regs.rs1Addr];
      ops.rs2Data <= (regs.rs2Addr == '0) ? '0 : regArray[regs.rs2Addr];
      if (writeEn && regs.rd != '0) begin
         regArray[regs.rd] <= writeData;  // x0 never written
      end
   end

endmodule

// File: rtl/instrDecoder.sv
// Instruction decoder latching the fetched word and deriving fields and immediates
module instrDecoder import riscvIsaPkg::*; (
   input  logic            clk,
   input  logic            latchInstr,
   input  logic [XLEN-1:0] memRdata,
   decodeIf.decoder        dec
);

   logic [31:2]     instr;  // Bits 1:0 always 11 in RV32I
   opcodeT          opcode;
   logic [XLEN-1:0] immI;
   logic [XLEN-1:0] immS;
   logic [XLEN-1:0] immB;
   logic [XLEN-1:0] immJ;
   logic [XLEN-1:0] immU;

   always_ff @(posedge clk) begin
      if (latchInstr) instr <= memRdata[31:2];  // Word valid in StWaitInstr
   end

   always_comb begin
      case (instr[6:2])
         OpLoad, OpAluImm, OpAuipc, OpStore, OpAluReg,
         OpLui, OpBranch, OpJalr, OpJal: opcode = opcodeT'(instr[6:2]);
         default:                        opcode = OpIllegal;
      endcase
   end

   // The five immediate formats
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign immU = {instr[31:12], 12'b0};

   assign dec.opcode   = opcode;
   assign dec.funct3   = instr[14:12];
   assign dec.rd       = instr[11:7];
   assign dec.rs1Addr  = instr[19:15];
   assign dec.rs2Addr  = instr[24:20];
   assign dec.aluImm   = immI;
   assign dec.upperImm = immU;
   assign dec.altOp    = instr[30];
   assign dec.isRegOp  = instr[5];   // 0 for ADDI, so bit 30 of the imm is no SUB

   // Second adder operand, I format for loads and JALR
   assign dec.addrImm = (opcode == OpJal)    ? immJ :
                        (opcode == OpAuipc)  ? immU :
                        (opcode == OpStore)  ? immS :
                        (opcode == OpBranch) ? immB : immI;

endmodule

// File: rtl/coreIf.sv
// Decode and operand interfaces between the core blocks
interface decodeIf import riscvIsaPkg::*; ();
   opcodeT                  opcode;
   logic [Funct3Width-1:0]  funct3;
   logic [RegAddrWidth-1:0] rd;
   logic [RegAddrWidth-1:0] rs1Addr;
   logic [RegAddrWidth-1:0] rs2Addr;
   logic [XLEN-1:0]         aluImm;    // I-format immediate
   logic [XLEN-1:0]         addrImm;   // Immediate for the address adder
   logic [XLEN-1:0]         upperImm;  // U-format immediate
   logic                    altOp;     // SUB and SRA select
   logic                    isRegOp;   // Register form of the ALU op

   modport decoder (output opcode, funct3, rd, rs1Addr, rs2Addr, aluImm, addrImm,
                    upperImm, altOp, isRegOp);
   modport regs    (input rd, rs1Addr, rs2Addr);
   modport alu     (input opcode, funct3, aluImm, altOp, isRegOp);
   modport ctrl    (input opcode, rd, addrImm, upperImm);
endinterface

interface operandIf import riscvIsaPkg::*; ();
   logic [XLEN-1:0] rs1Data;
   logic [XLEN-1:0] rs2Data;
   logic            aluStart;     // One-cycle strobe
   logic [XLEN-1:0] aluResult;
   logic            aluBusy;      // Serial shift in progress
   logic            branchTaken;  // Latched branch predicate

   modport regs (output rs1Data, rs2Data);
   modport alu  (input rs1Data, rs2Data, aluStart, output aluResult, aluBusy, branchTaken);
   modport ctrl (input rs1Data, rs2Data, aluResult, aluBusy, branchTaken, output aluStart);
endinterface

// File: rtl/coreCfgPkg.sv
// Core microarchitecture definitions for addressing and control states
package coreCfgPkg;

   localparam int AddrWidth  = 24;  // Internal address and PC width
   localparam int StateWidth = 8;   // One bit per control state

   // First fetch address after reset
   localparam logic [AddrWidth-1:0] ResetAddr = '0;

   // One-hot control states
   typedef enum logic [StateWidth-1:0] {
      StFetchInstr = 8'b0000_0001,  // Instruction read strobe
      StWaitInstr  = 8'b0000_0010,  // Instruction word on the bus, latch it
      StFetchRegs  = 8'b0000_0100,  // Register reads in flight
      StAddrAlu    = 8'b0000_1000,  // Address adder and ALU start
      StExecute    = 8'b0001_0000,  // Next PC, next address, write-back
      StLoad       = 8'b0010_0000,  // Data read strobe
      StWaitAluMem = 8'b0100_0000,  // Load data or shift completion
      StStore      = 8'b1000_0000   // Write mask out for one cycle
   } stateT;

endpackage

// File: rtl/riscvIsaPkg.sv
// RV32I instruction set definitions for field widths and encodings
package riscvIsaPkg;

   localparam int XLEN         = 32;        // Data word width
   localparam int RegAddrWidth = 5;         // Register index width
   localparam int NumRegs      = 32;        // x0 to x31
   localparam int ShamtWidth   = 5;         // Shift amount field
   localparam int Funct3Width  = 3;
   localparam int NumByteLanes = XLEN / 8;  // Write mask width

   // Major opcode, instruction bits 6 to 2
   typedef enum logic [4:0] {
      OpLoad    = 5'b00000,  // rd <- mem[rs1+immI]
      OpAluImm  = 5'b00100,  // rd <- rs1 op immI
      OpAuipc   = 5'b00101,  // rd <- PC + immU
      OpStore   = 5'b01000,  // mem[rs1+immS] <- rs2
      OpAluReg  = 5'b01100,  // rd <- rs1 op rs2
      OpLui     = 5'b01101,  // rd <- immU
      OpBranch  = 5'b11000,  // if (rs1 op rs2) PC <- PC+immB
      OpJalr    = 5'b11001,  // rd <- PC+4, PC <- rs1+immI
      OpJal     = 5'b11011,  // rd <- PC+4, PC <- PC+immJ
      OpIllegal = 5'b11111   // Anything else
   } opcodeT;

   typedef enum logic [2:0] {
      FnAddSub = 3'b000, FnSll = 3'b001, FnSlt = 3'b010, FnSltu = 3'b011,
      FnXor    = 3'b100, FnSr  = 3'b101, FnOr  = 3'b110, FnAnd  = 3'b111
   } aluFuncT;

   typedef enum logic [2:0] {
      BrEq  = 3'b000, BrNe  = 3'b001, BrLt  = 3'b100,
      BrGe  = 3'b101, BrLtu = 3'b110, BrGeu = 3'b111
   } branchFuncT;

endpackage
